/* src/loadPkg.sv */
package loadPkg;

    localparam int WordW   = 32;
    localparam int OpcodeW = 6;

    typedef logic [WordW-1:0]   word_t;   // memory word and result
    typedef logic [WordW-1:0]   addr_t;   // effective address
    typedef logic [WordW-1:0]   instr_t;  // full instruction word
    typedef logic [OpcodeW-1:0] opcode_t; // primary opcode, instr bits 31:26

    // supported load opcodes
    localparam opcode_t OpLw  = 6'd35;
    localparam opcode_t OpLb  = 6'd32;
    localparam opcode_t OpLbu = 6'd36;
    localparam opcode_t OpLh  = 6'd33;
    localparam opcode_t OpLhu = 6'd37;
    localparam opcode_t OpLui = 6'd15;

    localparam int NumLanes  = 4;
    localparam int LaneDepth = 2; // fifo entries per lane

    // credits the sender holds after reset
    localparam int TotalCredits = NumLanes * LaneDepth;

    typedef logic [$clog2(NumLanes)-1:0] laneSel_t;
    typedef logic [$clog2(TotalCredits+1)-1:0] credit_t;

    // lane fifo bookkeeping
    typedef logic [$clog2(LaneDepth)-1:0]   fifoPtr_t;
    typedef logic [$clog2(LaneDepth+1)-1:0] fifoCount_t;

    typedef logic [1:0] byteOffset_t; // address bits 1:0

endpackage

/* src/laneIf.sv */
interface laneIf;
    import loadPkg::*;

    // dispatcher to lane
    logic   push;
    addr_t  pushAddr;
    instr_t pushInstr;
    word_t  pushData;

    // lane head, combinational
    logic   nonEmpty;
    word_t  result;
    logic   error;

    // collector to lane
    logic   pop;

    modport dispatch (
        output push, pushAddr, pushInstr, pushData
    );

    modport lane (
        input  push, pushAddr, pushInstr, pushData, pop,
        output nonEmpty, result, error
    );

    modport collect (
        input  nonEmpty, result, error,
        output pop
    );

endinterface

/* src/loadDispatcher.sv */
module loadDispatcher (
    input  logic            clk,
    input  logic            reset,
    input  logic            reqValid,
    input  loadPkg::addr_t  reqAddr,
    input  loadPkg::instr_t reqInstr,
    input  loadPkg::word_t  reqData,
    laneIf.dispatch         lanes [loadPkg::NumLanes]
);
    import loadPkg::*;

    laneSel_t lanePtr; // lane that takes the next request

    // one payload register shared by all lanes
    addr_t  addrQ;
    instr_t instrQ;
    word_t  dataQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            lanePtr <= '0;
        end else if (reqValid) begin
            if (lanePtr == laneSel_t'(NumLanes - 1)) begin
                lanePtr <= '0;
            end else begin
                lanePtr <= lanePtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            addrQ  <= reqAddr;
            instrQ <= reqInstr;
            dataQ  <= reqData;
        end
    end

    // per lane push strobe, only the pointed lane fires
    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        always_ff @(posedge clk) begin
            if (reset) begin
                lanes[i].push <= 1'b0;
            end else begin
                lanes[i].push <= reqValid && (lanePtr == laneSel_t'(i));
            end
        end

        assign lanes[i].pushAddr  = addrQ;
        assign lanes[i].pushInstr = instrQ;
        assign lanes[i].pushData  = dataQ;
    end

endmodule

/* src/loadAlignLane.sv */
module loadAlignLane (
    input logic clk,
    input logic reset,
    laneIf.lane port
);
    import loadPkg::*;

    addr_t  addrMem  [LaneDepth];
    instr_t instrMem [LaneDepth];
    word_t  dataMem  [LaneDepth];

    fifoPtr_t   wrPtr;
    fifoPtr_t   rdPtr;
    fifoCount_t count;

    addr_t       headAddr;
    instr_t      headInstr;
    word_t       headData;
    opcode_t     opcode;
    byteOffset_t offset;
    logic [7:0]  selByte;
    logic [15:0] selHalf;

    function automatic fifoPtr_t nextPtr(fifoPtr_t ptr);
        return (ptr == fifoPtr_t'(LaneDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (port.push) begin
            addrMem[wrPtr]  <= port.pushAddr;
            instrMem[wrPtr] <= port.pushInstr;
            dataMem[wrPtr]  <= port.pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (port.push) wrPtr <= nextPtr(wrPtr);
            if (port.pop) rdPtr <= nextPtr(rdPtr);
            case ({port.push, port.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    assign port.nonEmpty = (count != '0);

    assign headAddr  = addrMem[rdPtr];
    assign headInstr = instrMem[rdPtr];
    assign headData  = dataMem[rdPtr];
    assign opcode    = headInstr[31:26];
    assign offset    = headAddr[1:0];

    // big endian, offset 0 is the top byte
    always_comb begin
        case (offset)
            2'd0:    selByte = headData[31:24];
            2'd1:    selByte = headData[23:16];
            2'd2:    selByte = headData[15:8];
            default: selByte = headData[7:0];
        endcase
    end

    assign selHalf = offset[1] ? headData[15:0] : headData[31:16];

    // zero data with error unless a rule below accepts the load
    always_comb begin
        port.result = '0;
        port.error  = 1'b1;
        case (opcode)
            OpLw: begin
                if (offset == 2'd0) begin
                    port.result = headData;
                    port.error  = 1'b0;
                end
            end
            OpLb: begin
                port.result = {{24{selByte[7]}}, selByte}; // sign extend
                port.error  = 1'b0;
            end
            OpLbu: begin
                port.result = {24'h000000, selByte};
                port.error  = 1'b0;
            end
            OpLh: begin
                if (!offset[0]) begin // offsets 0 and 2 only
                    port.result = {{16{selHalf[15]}}, selHalf};
                    port.error  = 1'b0;
                end
            end
            OpLhu: begin
                if (!offset[0]) begin
                    port.result = {16'h0000, selHalf};
                    port.error  = 1'b0;
                end
            end
            OpLui: begin
                // address is ignored here
                port.result = {headInstr[15:0], 16'h0000};
                port.error  = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

/* src/loadCollector.sv */
module loadCollector (
    input  logic           clk,
    input  logic           reset,
    laneIf.collect         lanes [loadPkg::NumLanes],
    input  logic           respCredit,
    output logic           reqCredit,
    output logic           respValid,
    output loadPkg::word_t respData,
    output logic           respError
);
    import loadPkg::*;

    logic  laneReady  [NumLanes];
    word_t laneResult [NumLanes];
    logic  laneError  [NumLanes];

    laneSel_t headPtr; // lane holding the oldest result
    credit_t  credits; // downstream grants not yet used
    logic     popFire;

    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        assign laneReady[i]  = lanes[i].nonEmpty;
        assign laneResult[i] = lanes[i].result;
        assign laneError[i]  = lanes[i].error;
        assign lanes[i].pop  = popFire && (headPtr == laneSel_t'(i));
    end

    // oldest result leaves only with a downstream credit in hand
    assign popFire = laneReady[headPtr] && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= '0;
        end else if (respCredit && !popFire) begin
            credits <= credits + 1'b1;
        end else if (!respCredit && popFire) begin
            credits <= credits - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            headPtr <= '0;
        end else if (popFire) begin
            if (headPtr == laneSel_t'(NumLanes - 1)) begin
                headPtr <= '0;
            end else begin
                headPtr <= headPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            respValid <= 1'b0;
        end else begin
            respValid <= popFire;
        end
    end

    always_ff @(posedge clk) begin
        if (popFire) begin
            respData  <= laneResult[headPtr];
            respError <= laneError[headPtr];
        end
    end

    // the fifo slot is free once its result goes out
    assign reqCredit = respValid;

endmodule

/* src/loadUnit.sv */
module loadUnit (
    input  logic            clk,
    input  logic            reset,

    input  logic            reqValid,
    input  loadPkg::addr_t  reqAddr,
    input  loadPkg::instr_t reqInstr,
    input  loadPkg::word_t  reqData,
    output logic            reqCredit,

    input  logic            respCredit,
    output logic            respValid,
    output loadPkg::word_t  respData,
    output logic            respError
);
    import loadPkg::*;

    laneIf laneBus [NumLanes] (); // one bundle per lane

    loadDispatcher uDispatch (
        .clk      (clk),
        .reset    (reset),
        .reqValid (reqValid),
        .reqAddr  (reqAddr),
        .reqInstr (reqInstr),
        .reqData  (reqData),
        .lanes    (laneBus)
    );

    // identical lanes, filled and drained in the same round-robin order
    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        loadAlignLane uLane (
            .clk   (clk),
            .reset (reset),
            .port  (laneBus[i])
        );
    end

    loadCollector uCollect (
        .clk        (clk),
        .reset      (reset),
        .lanes      (laneBus),
        .respCredit (respCredit),
        .reqCredit  (reqCredit),
        .respValid  (respValid),
        .respData   (respData),
        .respError  (respError)
    );

endmodule

/* testbench/loadUnit_chk.sv */
module loadUnitChk (
    input logic                          clk,
    input logic                          reset,
    input logic                          reqCredit,
    input logic                          respCredit,
    input logic                          respValid,
    input logic [loadPkg::NumLanes-1:0]  pop,
    input logic [loadPkg::NumLanes-1:0]  nonEmpty
);
    timeunit 1ns;
    timeprecision 100ps;

    int grantsHeld; // respCredit pulses not yet spent on a result

    always_ff @(posedge clk) begin
        if (reset) begin
            grantsHeld <= 0;
        end else begin
            grantsHeld <= grantsHeld + int'(respCredit) - int'(respValid);
        end
    end

    // collector never pops a lane that holds nothing
    popHasEntry: assert property (@(posedge clk) disable iff (reset) (pop & ~nonEmpty) == '0)
        else $error("a lane was popped while empty");

    // every result spends a grant taken earlier
    resultHasGrant: assert property (@(posedge clk) disable iff (reset)
        respValid |-> grantsHeld > 0)
        else $error("respValid without a granted respCredit");

    quietAfterReset: assert property (@(posedge clk) reset |=> !reqCredit && !respValid)
        else $error("reqCredit or respValid high right after reset");

endmodule

bind loadUnit loadUnitChk chk (
    .clk        (clk),
    .reset      (reset),
    .reqCredit  (reqCredit),
    .respCredit (respCredit),
    .respValid  (respValid),
    .pop        ({laneBus[3].pop, laneBus[2].pop, laneBus[1].pop, laneBus[0].pop}),
    .nonEmpty   ({laneBus[3].nonEmpty, laneBus[2].nonEmpty,
                  laneBus[1].nonEmpty, laneBus[0].nonEmpty})
);

/* testbench/loadUnitScoreboard.sv */
module loadUnitScoreboard (
    input logic            clk,
    input logic            reset,
    input logic            reqValid,
    input loadPkg::addr_t  reqAddr,
    input loadPkg::instr_t reqInstr,
    input loadPkg::word_t  reqData,
    input logic            reqCredit,
    input logic            respCredit,
    input logic            respValid,
    input loadPkg::word_t  respData,
    input logic            respError
);
    timeunit 1ns;
    timeprecision 100ps;
    import loadPkg::*;

    string testName = "reset";
    int grantCount;  // respCredit pulses seen
    int resultCount; // respValid cycles seen
    int creditCount; // reqCredit pulses seen
    int checkCount;
    int errorCount;

    logic [32:0] expQ [$]; // expected {error, data}, oldest first

    // expected {error, data} straight from the load rules
    function automatic logic [32:0] modelLoad(addr_t addr, instr_t instr, word_t data);
        int          offset;
        logic [7:0]  byteVal;
        logic [15:0] halfVal;
        logic [32:0] bad;
        offset  = int'(addr[1:0]);
        byteVal = 8'(data >> (8 * (3 - offset))); // offset 0 is the top byte
        bad     = {1'b1, 32'h0};
        case (instr[31:26])
            OpLw:  return (offset == 0) ? {1'b0, data} : bad;
            OpLb:  return {1'b0, 32'($signed(byteVal))};
            OpLbu: return {1'b0, 32'(byteVal)};
            OpLh, OpLhu: begin
                if (offset != 0 && offset != 2) return bad;
                halfVal = 16'(data >> (16 - 8 * offset));
                if (instr[31:26] == OpLh) return {1'b0, 32'($signed(halfVal))};
                return {1'b0, 32'(halfVal)};
            end
            OpLui: return {1'b0, instr[15:0], 16'h0000};
            default: return bad;
        endcase
    endfunction

    // inputs move on the falling edge, steady here
    always @(posedge clk) begin
        if (reset) begin
            expQ.delete();
            grantCount = 0;
        end else begin
            if (reqValid) expQ.push_back(modelLoad(reqAddr, reqInstr, reqData));
            if (respCredit) grantCount++;
        end
    end

    // outputs are registered, so look at them mid cycle
    always @(negedge clk) begin : compare
        logic [32:0] expected;
        if (!reset && respValid) begin
            if (resultCount >= grantCount) begin
                $display("result in test %s arrived without a granted credit", testName);
                errorCount++;
            end
            resultCount++;
            if (expQ.size() == 0) begin
                $display("result in test %s arrived with no request outstanding", testName);
                errorCount++;
            end else begin
                expected = expQ.pop_front();
                checkCount++;
                if ({respError, respData} !== expected) begin
                    $display("FAILED %s expected %h err %b, actual %h err %b", testName,
                             expected[31:0], expected[32], respData, respError);
                    errorCount++;
                end
            end
        end
        if (!reset && reqCredit) creditCount++;
        if (!reset && (reqCredit || respValid) && creditCount != resultCount) begin
            $display("test %s returned %0d reqCredit pulses for %0d results",
                     testName, creditCount, resultCount);
            errorCount++;
        end
    end

endmodule

/* testbench/loadUnitTb.sv */
module loadUnitTb;
    timeunit 1ns;
    timeprecision 100ps;
    import loadPkg::*;

    localparam int WaitLimit = 4000; // cycles any single wait may take

    logic   clk;
    logic   reset;
    logic   reqValid;
    addr_t  reqAddr;
    instr_t reqInstr;
    word_t  reqData;
    logic   reqCredit;
    logic   respCredit;
    logic   respValid;
    word_t  respData;
    logic   respError;

    int sendCredits; // upstream credits held by the sender
    int sentCount;
    int doneCount;
    int grantedCount;
    int grantPct;    // chance of a respCredit pulse per cycle
    int errBase;
    int testsRun;
    int testsFailed;
    bit hung;

    loadUnit dut (.*);
    loadUnitScoreboard sb (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one falling edge: credit bookkeeping and response side drive
    task automatic tick();
        @(negedge clk);
        if (reqCredit) sendCredits++;
        if (respValid) doneCount++;
        reqValid   = 1'b0;
        respCredit = 1'b0;
        if (grantedCount < sentCount && $urandom % 100 < grantPct) begin
            respCredit = 1'b1; // never more grants than results owed
            grantedCount++;
        end
    endtask

    task automatic sendReq(addr_t addr, instr_t instr, word_t data);
        int waited;
        waited = 0;
        tick();
        while (sendCredits == 0 && !hung) begin
            if (waited == WaitLimit) begin
                $display("timeout: no upstream credit came back in test %s", sb.testName);
                hung = 1'b1;
            end else begin
                tick();
                waited++;
            end
        end
        if (!hung) begin
            reqValid = 1'b1;
            reqAddr  = addr;
            reqInstr = instr;
            reqData  = data;
            sendCredits--;
            sentCount++;
        end
    endtask

    function automatic bit isLoadOp(opcode_t op);
        return op inside {OpLw, OpLb, OpLbu, OpLh, OpLhu, OpLui};
    endfunction

    // kinds 0 lw, 1 lui, 2 lb, 3 lbu, 4 aligned half, 5 odd half, 6 bad lw, 7 other opcode
    task automatic sendKind(int kind);
        addr_t      addr;
        word_t      data;
        opcode_t    op;
        logic [1:0] off;
        addr = $urandom & 32'hffff_fffc;
        data = $urandom;
        off  = 2'd0;
        case (kind)
            0: op = OpLw;
            1: begin op = OpLui; off = 2'($urandom); end
            2, 3: begin
                op  = (kind == 2) ? OpLb : OpLbu;
                off = 2'($urandom);
                if ($urandom % 2 == 1) data |= 32'h8080_8080; // negative bytes
            end
            4: begin
                op  = ($urandom % 2 == 1) ? OpLh : OpLhu;
                off = {1'($urandom), 1'b0};
                if ($urandom % 2 == 1) data |= 32'h8000_8000;
            end
            5: begin op = ($urandom % 2 == 1) ? OpLh : OpLhu; off = {1'($urandom), 1'b1}; end
            6: begin op = OpLw; off = 2'($urandom % 3 + 1); end
            default: begin
                op = 6'($urandom);
                if (isLoadOp(op)) op = op ^ 6'h10; // moves every load opcode off the list
            end
        endcase
        sendReq(addr | 32'(off), {op, 26'($urandom)}, data);
    endtask

    task automatic sendMany(int count, int kindLo, int kindHi, int gapPct);
        repeat (count) begin
            if (!hung && $urandom % 100 < gapPct) tick();
            if (!hung) sendKind(kindLo + int'($urandom % (kindHi - kindLo + 1)));
        end
    endtask

    task automatic startTest(string name);
        sb.testName = name;
        errBase     = sb.errorCount;
    endtask

    task automatic endTest();
        int waited;
        int errs;
        waited = 0;
        tick();
        while (doneCount != sentCount && !hung) begin
            if (waited == WaitLimit) begin
                $display("timeout: %0d results still missing in test %s",
                         sentCount - doneCount, sb.testName);
                hung = 1'b1;
            end else begin
                tick();
                waited++;
            end
        end
        tick(); // scoreboard finishes its last compare
        errs = sb.errorCount - errBase;
        testsRun++;
        if (hung || errs != 0) begin
            testsFailed++;
            $display("test %s: fail, %0d errors", sb.testName, errs);
        end else begin
            $display("test %s: pass", sb.testName);
        end
    endtask

    task automatic runTest(int id);
        grantPct = 60;
        case (id)
            1: begin startTest("alignedWord");  sendMany(40, 0, 1, 20); end
            2: begin startTest("byteLoad");     sendMany(60, 2, 3, 20); end
            3: begin startTest("halfMisalign"); sendMany(60, 4, 6, 20); end
            4: begin startTest("badOpcode");    sendMany(30, 7, 7, 20); end
            5: begin
                startTest("backPressure");
                grantPct = 0; // results stay in the lanes
                sendMany(TotalCredits, 0, 7, 0);
                repeat (30) tick();
                grantPct = 8; // sparse release
            end
            default: begin
                startTest("mixedRandom");
                repeat (6) begin
                    grantPct = 20 + int'($urandom % 70);
                    sendMany(50, 0, 7, 30);
                end
            end
        endcase
        endTest();
    endtask

    initial begin
        reset       = 1'b1;
        reqValid    = 1'b0;
        reqAddr     = '0;
        reqInstr    = '0;
        reqData     = '0;
        respCredit  = 1'b0;
        sendCredits = TotalCredits;
        grantPct    = 0;
        void'($urandom(32'h5ea3));
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int id = 1; id <= 6 && !hung; id++) runTest(id);

        $display("tests run %0d, failed %0d, results checked %0d, errors %0d",
                 testsRun, testsFailed, sb.checkCount, sb.errorCount);
        if (!hung && testsFailed == 0 && sb.errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* loadUnit.f */
src/loadPkg.sv
src/laneIf.sv
src/loadDispatcher.sv
src/loadAlignLane.sv
src/loadCollector.sv
src/loadUnit.sv
testbench/loadUnit_chk.sv
testbench/loadUnitScoreboard.sv
testbench/loadUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the loadUnit testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module loadUnitTb -Mdir obj_dir -f loadUnit.f
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

./obj_dir/VloadUnitTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
exit 1
